// File: rtl/sgd_pkg.sv
`default_nettype none

package sgd_pkg;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////

    // features per sample, also model words
    localparam int NUM_FEATURES  = 4;
    localparam int FEATURE_WIDTH = 8;
    // model words, labels, loss and gradients
    localparam int MODEL_WIDTH   = 32;
    // sample, batch and epoch counters
    localparam int COUNT_WIDTH   = 16;

    //////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////

    typedef logic signed [FEATURE_WIDTH-1:0]              feature_t;
    // feature i sits at bits [i*FEATURE_WIDTH +: FEATURE_WIDTH]
    typedef logic        [NUM_FEATURES*FEATURE_WIDTH-1:0] features_t;
    typedef logic signed [MODEL_WIDTH-1:0]                model_word_t;
    // word i sits at bits [i*MODEL_WIDTH +: MODEL_WIDTH]
    typedef logic        [NUM_FEATURES*MODEL_WIDTH-1:0]   model_vec_t;
    typedef logic        [COUNT_WIDTH-1:0]                count_t;
    // arithmetic right shift of the loss
    typedef logic        [$clog2(MODEL_WIDTH)-1:0]        shift_t;
    typedef logic        [$clog2(NUM_FEATURES)-1:0]       index_t;

    // training sequencer
    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_RUN,
        CTRL_WAIT_UPDATE,
        CTRL_WRITE_BACK,
        CTRL_DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: rtl/sgd_control.sv
`timescale 1ns/100ps
`default_nettype none

module sgd_control (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  start,
    input  wire sgd_pkg::count_t mini_batch_size,
    input  wire sgd_pkg::count_t number_of_samples,
    input  wire sgd_pkg::count_t number_of_epochs,
    input  wire sgd_pkg::shift_t step_shift,
    input  wire                  sample_valid,
    input  wire                  update_done,
    input  wire                  wb_done,
    output logic                 sample_ready,
    output logic                 take,
    output logic                 batch_end,
    output sgd_pkg::shift_t      step_shift_q,
    output logic                 wb_start,
    output logic                 done
);

    sgd_pkg::ctrl_state_t state;

    // latched configuration
    sgd_pkg::count_t      mbs_q;
    sgd_pkg::count_t      nsamp_q;
    sgd_pkg::count_t      nepoch_q;

    // position inside batch, epoch and run
    sgd_pkg::count_t      batch_cnt;
    sgd_pkg::count_t      sample_cnt;
    sgd_pkg::count_t      epoch_cnt;
    logic                 epoch_end;
    // pending update is the last one of the run
    logic                 final_q;

    // intake open only while running, closed during the update
    assign sample_ready = (state == sgd_pkg::CTRL_RUN);
    assign take         = sample_valid & sample_ready;
    assign done         = (state == sgd_pkg::CTRL_DONE);

    // batch closes on size or on the last sample of the epoch
    assign epoch_end    = (sample_cnt == nsamp_q - 1'b1);
    assign batch_end    = (batch_cnt == mbs_q - 1'b1) | epoch_end;

    //////////////////////////////////////////////////
    // configuration, taken on an accepted start
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if ((state == sgd_pkg::CTRL_IDLE || state == sgd_pkg::CTRL_DONE) && start) begin
            mbs_q        <= mini_batch_size;
            nsamp_q      <= number_of_samples;
            nepoch_q     <= number_of_epochs;
            step_shift_q <= step_shift;
        end
    end

    //////////////////////////////////////////////////
    // sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= sgd_pkg::CTRL_IDLE;
            batch_cnt  <= '0;
            sample_cnt <= '0;
            epoch_cnt  <= '0;
            final_q    <= 1'b0;
            wb_start   <= 1'b0;
        end else begin
            // single cycle strobe
            wb_start <= 1'b0;
            case (state)
                sgd_pkg::CTRL_IDLE, sgd_pkg::CTRL_DONE: begin
                    // start elsewhere is ignored
                    if (start) begin
                        state      <= sgd_pkg::CTRL_RUN;
                        batch_cnt  <= '0;
                        sample_cnt <= '0;
                        epoch_cnt  <= '0;
                        final_q    <= 1'b0;
                    end
                end
                sgd_pkg::CTRL_RUN: begin
                    if (take) begin
                        batch_cnt <= batch_end ? '0 : batch_cnt + 1'b1;
                        if (epoch_end) begin
                            sample_cnt <= '0;
                            epoch_cnt  <= epoch_cnt + 1'b1;
                        end else begin
                            sample_cnt <= sample_cnt + 1'b1;
                        end
                        // hold intake until the model has the new words
                        if (batch_end) begin
                            state   <= sgd_pkg::CTRL_WAIT_UPDATE;
                            final_q <= epoch_end && (epoch_cnt == nepoch_q - 1'b1);
                        end
                    end
                end
                sgd_pkg::CTRL_WAIT_UPDATE: begin
                    if (update_done) begin
                        if (final_q) begin
                            state    <= sgd_pkg::CTRL_WRITE_BACK;
                            wb_start <= 1'b1;
                        end else begin
                            state <= sgd_pkg::CTRL_RUN;
                        end
                    end
                end
                sgd_pkg::CTRL_WRITE_BACK: begin
                    if (wb_done) begin
                        state <= sgd_pkg::CTRL_DONE;
                    end
                end
                default: begin
                    state <= sgd_pkg::CTRL_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/sgd_dot_product.sv
`timescale 1ns/100ps
`default_nettype none

module sgd_dot_product (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       take,
    input  wire sgd_pkg::features_t   sample_features,
    input  wire sgd_pkg::model_word_t sample_label,
    input  wire                       batch_end,
    input  wire sgd_pkg::model_vec_t  model_vec,
    output logic                      dp_valid,
    output sgd_pkg::model_word_t      dp_value,
    output sgd_pkg::features_t        dp_features,
    output sgd_pkg::model_word_t      dp_label,
    output logic                      dp_batch_end
);

    localparam int FW = sgd_pkg::FEATURE_WIDTH;
    localparam int MW = sgd_pkg::MODEL_WIDTH;

    // stage one
    logic                 s1_valid;
    sgd_pkg::model_word_t s1_prod [sgd_pkg::NUM_FEATURES];
    sgd_pkg::features_t   s1_features;
    sgd_pkg::model_word_t s1_label;
    logic                 s1_batch_end;
    sgd_pkg::model_word_t s1_sum;

    // valid chain, one bit per stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            dp_valid <= 1'b0;
        end else begin
            s1_valid <= take;
            dp_valid <= s1_valid;
        end
    end

    //////////////////////////////////////////////////
    // stage one: products, wrapped to a model word
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int i = 0; i < sgd_pkg::NUM_FEATURES; i++) begin
            // sign extend the feature before the multiply
            s1_prod[i] <= sgd_pkg::model_word_t'(
                              sgd_pkg::feature_t'(sample_features[i*FW +: FW]))
                          * sgd_pkg::model_word_t'(model_vec[i*MW +: MW]);
        end
        // sideband rides with the sample
        s1_features  <= sample_features;
        s1_label     <= sample_label;
        s1_batch_end <= batch_end;
    end

    // adder tree, wraps at the word width
    always_comb begin
        s1_sum = '0;
        for (int i = 0; i < sgd_pkg::NUM_FEATURES; i++) begin
            s1_sum = s1_sum + s1_prod[i];
        end
    end

    //////////////////////////////////////////////////
    // stage two: registered sum
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        dp_value     <= s1_sum;
        dp_features  <= s1_features;
        dp_label     <= s1_label;
        dp_batch_end <= s1_batch_end;
    end

endmodule

`default_nettype wire

// File: rtl/sgd_gradient.sv
`timescale 1ns/100ps
`default_nettype none

module sgd_gradient (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       start,
    input  wire                       dp_valid,
    input  wire sgd_pkg::model_word_t dp_value,
    input  wire sgd_pkg::features_t   dp_features,
    input  wire sgd_pkg::model_word_t dp_label,
    input  wire                       dp_batch_end,
    input  wire sgd_pkg::shift_t      step_shift_q,
    output logic                      grad_valid,
    output sgd_pkg::model_vec_t       grad_vec
);

    localparam int FW = sgd_pkg::FEATURE_WIDTH;
    localparam int MW = sgd_pkg::MODEL_WIDTH;

    // loss stage
    sgd_pkg::model_word_t diff;
    logic                 l_valid;
    sgd_pkg::model_word_t l_loss;
    sgd_pkg::features_t   l_features;
    logic                 l_batch_end;

    // per feature running sums
    sgd_pkg::model_word_t acc [sgd_pkg::NUM_FEATURES];
    sgd_pkg::model_word_t acc_next [sgd_pkg::NUM_FEATURES];

    assign diff = dp_value - dp_label;

    //////////////////////////////////////////////////
    // stage one: (ax - b) >>> shift
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            l_valid <= 1'b0;
        end else begin
            l_valid <= dp_valid;
        end
    end

    always_ff @(posedge clk) begin
        // signed operand, so the shift keeps the sign
        l_loss      <= diff >>> step_shift_q;
        l_features  <= dp_features;
        l_batch_end <= dp_batch_end;
    end

    //////////////////////////////////////////////////
    // stage two: accumulate loss * feature
    //////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < sgd_pkg::NUM_FEATURES; i++) begin
            acc_next[i] = acc[i] + l_loss * sgd_pkg::model_word_t'(
                              sgd_pkg::feature_t'(l_features[i*FW +: FW]));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grad_valid <= 1'b0;
        end else begin
            // one pulse per finished batch
            grad_valid <= l_valid & l_batch_end;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < sgd_pkg::NUM_FEATURES; i++) begin
            if (start) begin
                acc[i] <= '0;
            end else if (l_valid) begin
                // batch end hands off the sums and restarts at zero
                acc[i] <= l_batch_end ? '0 : acc_next[i];
            end
        end
        if (l_valid && l_batch_end) begin
            for (int i = 0; i < sgd_pkg::NUM_FEATURES; i++) begin
                grad_vec[i*MW +: MW] <= acc_next[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/sgd_model.sv
`timescale 1ns/100ps
`default_nettype none

module sgd_model (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       start,
    input  wire                       grad_valid,
    input  wire sgd_pkg::model_vec_t  grad_vec,
    input  wire sgd_pkg::index_t      rd_index,
    output sgd_pkg::model_vec_t       model_vec,
    output logic                      update_done,
    output sgd_pkg::model_word_t      rd_word
);

    localparam int MW = sgd_pkg::MODEL_WIDTH;

    // model words x[0..3]
    sgd_pkg::model_word_t words [sgd_pkg::NUM_FEATURES];

    //////////////////////////////////////////////////
    // batch update
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int i = 0; i < sgd_pkg::NUM_FEATURES; i++) begin
            if (start) begin
                // every run trains from a zero model
                words[i] <= '0;
            end else if (grad_valid) begin
                words[i] <= words[i] - sgd_pkg::model_word_t'(grad_vec[i*MW +: MW]);
            end
        end
    end

    // commit strobe, same edge as the words
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            update_done <= 1'b0;
        end else begin
            update_done <= grad_valid;
        end
    end

    //////////////////////////////////////////////////
    // read ports
    //////////////////////////////////////////////////

    // full vector for the dot product
    always_comb begin
        for (int i = 0; i < sgd_pkg::NUM_FEATURES; i++) begin
            model_vec[i*MW +: MW] = words[i];
        end
    end

    // single word for write-back
    assign rd_word = words[rd_index];

endmodule

`default_nettype wire

// File: rtl/sgd_x_writeback.sv
`timescale 1ns/100ps
`default_nettype none

module sgd_x_writeback (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       wb_start,
    input  wire sgd_pkg::model_word_t rd_word,
    input  wire                       x_out_ready,
    output sgd_pkg::index_t           rd_index,
    output sgd_pkg::model_word_t      x_out_data,
    output logic                      x_out_valid,
    output logic                      x_out_last,
    output logic                      wb_done
);

    localparam sgd_pkg::index_t LAST_INDEX = sgd_pkg::index_t'(sgd_pkg::NUM_FEATURES - 1);

    // index of the next word to load, one ahead of the output
    sgd_pkg::index_t idx;
    logic            xfer;
    logic            load;

    assign rd_index = idx;
    assign xfer     = x_out_valid & x_out_ready;
    // load on launch, or on a transfer that is not the last
    assign load     = wb_start | (xfer & ~x_out_last);
    // final handshake of the stream
    assign wb_done  = xfer & x_out_last;

    //////////////////////////////////////////////////
    // output register and index walk
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx         <= '0;
            x_out_valid <= 1'b0;
            x_out_last  <= 1'b0;
        end else if (load) begin
            x_out_valid <= 1'b1;
            x_out_last  <= (idx == LAST_INDEX);
            idx         <= (idx == LAST_INDEX) ? '0 : idx + 1'b1;
        end else if (wb_done) begin
            // idx is back at 0, ready for the next run
            x_out_valid <= 1'b0;
            x_out_last  <= 1'b0;
        end
    end

    // word holds under back-pressure
    always_ff @(posedge clk) begin
        if (load) begin
            x_out_data <= rd_word;
        end
    end

endmodule

`default_nettype wire

// File: rtl/sgd_top.sv
`timescale 1ns/100ps
`default_nettype none

module sgd_top (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       start,
    input  wire sgd_pkg::count_t      mini_batch_size,
    input  wire sgd_pkg::count_t      number_of_samples,
    input  wire sgd_pkg::count_t      number_of_epochs,
    input  wire sgd_pkg::shift_t      step_shift,
    // sample stream
    input  wire sgd_pkg::features_t   sample_features,
    input  wire sgd_pkg::model_word_t sample_label,
    input  wire                       sample_valid,
    output wire                       sample_ready,
    // model stream
    output wire sgd_pkg::model_word_t x_out_data,
    output wire                       x_out_valid,
    input  wire                       x_out_ready,
    output wire                       x_out_last,
    output wire                       done
);

    // control
    logic                 take;
    logic                 batch_end;
    sgd_pkg::shift_t      step_shift_q;
    logic                 wb_start;
    logic                 wb_done;

    // dot product to gradient
    logic                 dp_valid;
    sgd_pkg::model_word_t dp_value;
    sgd_pkg::features_t   dp_features;
    sgd_pkg::model_word_t dp_label;
    logic                 dp_batch_end;

    // gradient to model, model to the rest
    logic                 grad_valid;
    sgd_pkg::model_vec_t  grad_vec;
    sgd_pkg::model_vec_t  model_vec;
    logic                 update_done;
    sgd_pkg::index_t      rd_index;
    sgd_pkg::model_word_t rd_word;

    //////////////////////////////////////////////////
    // sequencer and datapath
    //////////////////////////////////////////////////

    sgd_control u_control (
        .clk               (clk),
        .rst_n             (rst_n),
        .start             (start),
        .mini_batch_size   (mini_batch_size),
        .number_of_samples (number_of_samples),
        .number_of_epochs  (number_of_epochs),
        .step_shift        (step_shift),
        .sample_valid      (sample_valid),
        .update_done       (update_done),
        .wb_done           (wb_done),
        .sample_ready      (sample_ready),
        .take              (take),
        .batch_end         (batch_end),
        .step_shift_q      (step_shift_q),
        .wb_start          (wb_start),
        .done              (done)
    );

    sgd_dot_product u_dot_product (
        .clk             (clk),
        .rst_n           (rst_n),
        .take            (take),
        .sample_features (sample_features),
        .sample_label    (sample_label),
        .batch_end       (batch_end),
        .model_vec       (model_vec),
        .dp_valid        (dp_valid),
        .dp_value        (dp_value),
        .dp_features     (dp_features),
        .dp_label        (dp_label),
        .dp_batch_end    (dp_batch_end)
    );

    sgd_gradient u_gradient (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .dp_valid     (dp_valid),
        .dp_value     (dp_value),
        .dp_features  (dp_features),
        .dp_label     (dp_label),
        .dp_batch_end (dp_batch_end),
        .step_shift_q (step_shift_q),
        .grad_valid   (grad_valid),
        .grad_vec     (grad_vec)
    );

    sgd_model u_model (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .grad_valid  (grad_valid),
        .grad_vec    (grad_vec),
        .rd_index    (rd_index),
        .model_vec   (model_vec),
        .update_done (update_done),
        .rd_word     (rd_word)
    );

    sgd_x_writeback u_x_writeback (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_start    (wb_start),
        .rd_word     (rd_word),
        .x_out_ready (x_out_ready),
        .rd_index    (rd_index),
        .x_out_data  (x_out_data),
        .x_out_valid (x_out_valid),
        .x_out_last  (x_out_last),
        .wb_done     (wb_done)
    );

endmodule

`default_nettype wire

// File: include/sgd_tb_model.svh
`ifndef SGD_TB_MODEL_SVH
`define SGD_TB_MODEL_SVH

//////////////////////////////////////////////////
// reference training, exact integer math
//////////////////////////////////////////////////

// feature i of a sample, sign extended to a model word
function automatic sgd_pkg::model_word_t feature_value(input sgd_pkg::features_t f, input int i);
    sgd_pkg::feature_t b;
    b = f[i*sgd_pkg::FEATURE_WIDTH +: sgd_pkg::FEATURE_WIDTH];
    return sgd_pkg::model_word_t'(b);
endfunction

// word i of a packed model vector
function automatic sgd_pkg::model_word_t model_word(input sgd_pkg::model_vec_t x, input int i);
    return x[i*sgd_pkg::MODEL_WIDTH +: sgd_pkg::MODEL_WIDTH];
endfunction

// full 64-bit product, then keep the low word
function automatic sgd_pkg::model_word_t wrapped_product(
    input sgd_pkg::model_word_t a,
    input sgd_pkg::model_word_t b
);
    longint p;
    p = longint'(a) * longint'(b);
    return sgd_pkg::model_word_t'(p[sgd_pkg::MODEL_WIDTH-1:0]);
endfunction

// exact sum of products, wrapped once at the end
function automatic sgd_pkg::model_word_t dot_with_model(
    input sgd_pkg::features_t f,
    input sgd_pkg::model_vec_t x
);
    longint acc;
    acc = 0;
    for (int i = 0; i < sgd_pkg::NUM_FEATURES; i++) begin
        acc = acc + longint'(feature_value(f, i)) * longint'(model_word(x, i));
    end
    return sgd_pkg::model_word_t'(acc[sgd_pkg::MODEL_WIDTH-1:0]);
endfunction

// (dot - label) >>> shift, arithmetic
function automatic sgd_pkg::model_word_t shifted_loss(
    input sgd_pkg::model_word_t dot,
    input sgd_pkg::model_word_t label,
    input int shift
);
    sgd_pkg::model_word_t diff;
    diff = dot - label;
    return diff >>> shift;
endfunction

// whole run: zero model, mini-batches, epochs
function automatic sgd_pkg::model_vec_t train_reference(
    input sgd_pkg::features_t  feats [$],
    input sgd_pkg::model_word_t labels [$],
    input int batch_size,
    input int epochs,
    input int shift
);
    sgd_pkg::model_vec_t  x;
    sgd_pkg::model_word_t g [sgd_pkg::NUM_FEATURES];
    sgd_pkg::model_word_t loss;
    int in_batch;
    x = '0;
    for (int j = 0; j < sgd_pkg::NUM_FEATURES; j++) begin
        g[j] = '0;
    end
    for (int e = 0; e < epochs; e++) begin
        in_batch = 0;
        for (int s = 0; s < feats.size(); s++) begin
            // model stays fixed inside a batch
            loss = shifted_loss(dot_with_model(feats[s], x), labels[s], shift);
            for (int j = 0; j < sgd_pkg::NUM_FEATURES; j++) begin
                g[j] = g[j] + wrapped_product(loss, feature_value(feats[s], j));
            end
            in_batch++;
            // size reached or last sample of the epoch
            if (in_batch == batch_size || s == feats.size() - 1) begin
                for (int j = 0; j < sgd_pkg::NUM_FEATURES; j++) begin
                    x[j*sgd_pkg::MODEL_WIDTH +: sgd_pkg::MODEL_WIDTH] = model_word(x, j) - g[j];
                    g[j] = '0;
                end
                in_batch = 0;
            end
        end
    end
    return x;
endfunction

`endif

// File: dv/sgd_tb.sv
`timescale 1ns/100ps
`default_nettype none

module sgd_tb;

    localparam int MW        = sgd_pkg::MODEL_WIDTH;
    localparam int NUM_TESTS = 5;

    //////////////////////////////////////////////////
    // test table, one column per setting
    //////////////////////////////////////////////////

    // 0: single batch, 1: partial batch and gaps, 2: back-pressure
    // 3: restart after done, 4: shift 0 and full-range labels
    localparam int T_MBS       [NUM_TESTS] = '{4, 3, 2, 3, 4};
    localparam int T_SAMPLES   [NUM_TESTS] = '{4, 8, 5, 7, 6};
    localparam int T_EPOCHS    [NUM_TESTS] = '{1, 3, 2, 2, 2};
    localparam int T_SHIFT     [NUM_TESTS] = '{4, 6, 5, 3, 0};
    localparam int T_GAPS      [NUM_TESTS] = '{0, 1, 0, 1, 1};
    localparam int T_STALL_OUT [NUM_TESTS] = '{0, 0, 1, 1, 1};
    localparam int T_BIG_LABEL [NUM_TESTS] = '{0, 0, 0, 0, 1};

    logic                 clk;
    logic                 rst_n;
    logic                 start;
    sgd_pkg::count_t      mini_batch_size;
    sgd_pkg::count_t      number_of_samples;
    sgd_pkg::count_t      number_of_epochs;
    sgd_pkg::shift_t      step_shift;
    sgd_pkg::features_t   sample_features;
    sgd_pkg::model_word_t sample_label;
    logic                 sample_valid;
    logic                 sample_ready;
    sgd_pkg::model_word_t x_out_data;
    logic                 x_out_valid;
    logic                 x_out_ready;
    logic                 x_out_last;
    logic                 done;

    integer               seed;
    int                   error_count;
    int                   check_count;
    int                   tests_failed;
    // samples of the current test, replayed every epoch
    sgd_pkg::features_t   feat_q [$];
    sgd_pkg::model_word_t label_q [$];

    `include "sgd_tb_model.svh"

    sgd_top DUT (
        .clk               (clk),
        .rst_n             (rst_n),
        .start             (start),
        .mini_batch_size   (mini_batch_size),
        .number_of_samples (number_of_samples),
        .number_of_epochs  (number_of_epochs),
        .step_shift        (step_shift),
        .sample_features   (sample_features),
        .sample_label      (sample_label),
        .sample_valid      (sample_valid),
        .sample_ready      (sample_ready),
        .x_out_data        (x_out_data),
        .x_out_valid       (x_out_valid),
        .x_out_ready       (x_out_ready),
        .x_out_last        (x_out_last),
        .done              (done)
    );

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [MW-1:0] actual,
                               input logic [MW-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL at %0d ns: %s, got %0h expected %0h", $time, what, actual, expected);
        end
    endtask

    // fresh features and labels for one test
    task automatic make_samples(input int n, input int big_label);
        sgd_pkg::features_t f;
        sgd_pkg::model_word_t l;
        feat_q.delete();
        label_q.delete();
        for (int i = 0; i < n; i++) begin
            f = $random(seed);
            // small labels keep the model in range, big ones force wraps
            l = big_label ? $random(seed) : $random(seed) % 256;
            feat_q.push_back(f);
            label_q.push_back(l);
        end
    endtask

    //////////////////////////////////////////////////
    // stream drivers, entered 1 ns after an edge
    //////////////////////////////////////////////////

    task automatic drive_samples(input int epochs, input int gaps);
        logic accepted;
        for (int e = 0; e < epochs; e++) begin
            for (int s = 0; s < feat_q.size(); s++) begin
                // optional idle cycles before each sample
                while (gaps != 0 && ($random(seed) & 3) == 0) begin
                    sample_valid = 1'b0;
                    @(posedge clk);
                    #1;
                end
                sample_valid    = 1'b1;
                sample_features = feat_q[s];
                sample_label    = label_q[s];
                // hold until a handshake edge
                do begin
                    @(negedge clk);
                    accepted = sample_ready;
                    @(posedge clk);
                    #1;
                end while (!accepted);
            end
        end
        sample_valid = 1'b0;
    endtask

    task automatic collect_words(input int stall_out, input sgd_pkg::model_vec_t expected);
        int count;
        logic held;
        sgd_pkg::model_word_t held_word;
        count = 0;
        held  = 1'b0;
        while (count < sgd_pkg::NUM_FEATURES) begin
            @(posedge clk);
            #1;
            x_out_ready = (stall_out != 0) ? $random(seed) & 1 : 1'b1;
            // outputs are stable at the falling edge
            @(negedge clk);
            if (held && !x_out_valid) begin
                // a stalled word must not be withdrawn
                check_value("valid held under back-pressure", x_out_valid, 1'b1);
                held = 1'b0;
            end
            if (x_out_valid) begin
                if (held) begin
                    check_value("word held under back-pressure", x_out_data, held_word);
                end
                if (x_out_ready) begin
                    check_value($sformatf("model word %0d", count), x_out_data,
                                expected[count*MW +: MW]);
                    check_value($sformatf("last flag on word %0d", count), x_out_last,
                                count == sgd_pkg::NUM_FEATURES - 1);
                    count++;
                    held = 1'b0;
                end else begin
                    held      = 1'b1;
                    held_word = x_out_data;
                end
            end
        end
        @(posedge clk);
        #1;
        x_out_ready = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // one table row
    //////////////////////////////////////////////////

    task automatic run_test(input int t);
        int errors_before;
        sgd_pkg::model_vec_t expected;
        errors_before = error_count;
        make_samples(T_SAMPLES[t], T_BIG_LABEL[t]);
        expected = train_reference(feat_q, label_q, T_MBS[t], T_EPOCHS[t], T_SHIFT[t]);

        mini_batch_size   = sgd_pkg::count_t'(T_MBS[t]);
        number_of_samples = sgd_pkg::count_t'(T_SAMPLES[t]);
        number_of_epochs  = sgd_pkg::count_t'(T_EPOCHS[t]);
        step_shift        = sgd_pkg::shift_t'(T_SHIFT[t]);
        start             = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        // done drops and intake opens one cycle after start
        @(negedge clk);
        check_value("done after start", done, 1'b0);
        check_value("sample_ready after start", sample_ready, 1'b1);
        @(posedge clk);
        #1;

        fork
            drive_samples(T_EPOCHS[t], T_GAPS[t]);
            collect_words(T_STALL_OUT[t], expected);
        join

        // wait for done, watchdog bounds this
        do begin
            @(negedge clk);
        end while (!done);
        check_value("x_out_valid at done", x_out_valid, 1'b0);
        check_value("sample_ready at done", sample_ready, 1'b0);
        @(posedge clk);
        #1;

        if (error_count != errors_before) begin
            tests_failed++;
        end
        $display("test %0d: batch %0d, %0d samples, %0d epochs, shift %0d, %s", t,
                 T_MBS[t], T_SAMPLES[t], T_EPOCHS[t], T_SHIFT[t],
                 (error_count == errors_before) ? "passed" : "failed");
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        seed              = 32'ha51f;
        error_count       = 0;
        check_count       = 0;
        tests_failed      = 0;
        rst_n             = 1'b0;
        start             = 1'b0;
        mini_batch_size   = '0;
        number_of_samples = '0;
        number_of_epochs  = '0;
        step_shift        = '0;
        sample_features   = '0;
        sample_label      = '0;
        sample_valid      = 1'b0;
        x_out_ready       = 1'b0;

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // outputs quiet out of reset
        @(negedge clk);
        check_value("sample_ready after reset", sample_ready, 1'b0);
        check_value("x_out_valid after reset", x_out_valid, 1'b0);
        check_value("done after reset", done, 1'b0);
        $display("reset: %s", (error_count == 0) ? "passed" : "failed");
        @(posedge clk);
        #1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 NUM_TESTS, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // run length bound from the table
    initial begin : watchdog
        int limit;
        limit = 20;
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit = limit + T_SAMPLES[t] * T_EPOCHS[t] * 12 + 200;
        end
        repeat (limit) @(posedge clk);
        $display("timeout: the DUT did not finish within %0d cycles, run stopped", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sgd_top.f
+incdir+include
rtl/sgd_pkg.sv
rtl/sgd_control.sv
rtl/sgd_dot_product.sv
rtl/sgd_gradient.sv
rtl/sgd_model.sv
rtl/sgd_x_writeback.sv
rtl/sgd_top.sv
dv/sgd_tb.sv
